//--- Bender.yml
package:
  name: dazzler_io

sources:
  - common/dazzler_bus_pkg.sv
  - common/dazzler_ctrl_pkg.sv
  - spi/spi_engine.sv
  - wii/wii_report.sv
  - source/io_regs.sv
  - source/dazzler_io_top.sv
  - target: test
    files:
      - testbench/tb_dazzler_io.sv

//--- common/dazzler_bus_pkg.sv
package dazzler_bus_pkg;

  // one bus word, 12-bit word address
  localparam int BUS_DW = 16;
  localparam int BUS_AW = 12;

  //////////////////////////////
  // register map
  //////////////////////////////
  typedef enum logic [BUS_AW-1:0] {
    WII1_LO  = 12'h004,
    WII1_MID = 12'h005,
    WII1_HI  = 12'h006,
    WII2_LO  = 12'h007,
    WII2_MID = 12'h008,
    WII2_HI  = 12'h009,
    SPI_CTL  = 12'h010,
    SYSCTL   = 12'h014,
    TICKS    = 12'h015,
    SPI_DATA = 12'h020,
    SPI_STAT = 12'h021
  } io_addr_e;

  // SPI_CTL pin order, msb down: cs sck io3 io2 miso mosi
  localparam int SPI_CTL_W    = 6;
  localparam int SPI_CS_BIT   = 5;
  localparam int SPI_SCK_BIT  = 4;
  localparam int SPI_MOSI_BIT = 0;

  localparam int SPI_IDLE_BIT = 0;  // in SPI_STAT

  localparam int SYSCTL_PD_BIT = 0;  // power-down pin

endpackage

//--- common/dazzler_ctrl_pkg.sv
package dazzler_ctrl_pkg;

  // raw controller report, three bus words
  localparam int REPORT_W = 48;

  //////////////////////////////
  // stick and trigger fields
  //////////////////////////////
  localparam int STICK_L_W = 6;  // lx, ly
  localparam int STICK_R_W = 5;  // rx, ry, lt, rt

  // each decoded field sits in its own byte, zero padded
  localparam int FIELD_W = 8;

  //////////////////////////////
  // host readout
  //////////////////////////////
  // decoded 2, raw 2, decoded 1, raw 1
  localparam int READOUT_W = 4 * REPORT_W;

  localparam int READOUT_IX_W = $clog2(READOUT_W);

endpackage

//--- filelist.f
common/dazzler_bus_pkg.sv
common/dazzler_ctrl_pkg.sv
spi/spi_engine.sv
wii/wii_report.sv
source/io_regs.sv
source/dazzler_io_top.sv
testbench/tb_dazzler_io.sv

//--- source/dazzler_io_top.sv
`timescale 1ns/100ps

module dazzler_io_top
  import dazzler_bus_pkg::*;
  import dazzler_ctrl_pkg::*;
#(
  parameter int SPI_LEN     = 16,
  parameter int SYNC_STAGES = 2
) (
  input  logic              clk50,
  input  logic              SCKclock,

  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [BUS_AW-1:0] wb_adr_i,
  input  logic [BUS_DW-1:0] wb_dat_i,
  output logic [BUS_DW-1:0] wb_dat_o,
  output logic              wb_ack_o,

  input  logic              spi_miso_i,
  output logic              spi_sck_o,
  output logic              spi_mosi_o,
  output logic              spi_cs_o,

  input  logic              host_load_i,
  input  logic              host_sck_i,
  output logic              host_miso_o,

  output logic              power_down_o
);

  logic                 spi_start;
  logic [BUS_DW-1:0]    spi_tx;
  logic [BUS_DW-1:0]    spi_rx;
  logic                 spi_idle;
  logic [SPI_CTL_W-1:0] spi_ctl;
  logic                 eng_sck;
  logic                 eng_mosi;

  logic [REPORT_W-1:0]  wii1_report;
  logic [REPORT_W-1:0]  wii2_report;

  io_regs i_io_regs (
    .clk50         (clk50),
    .SCKclock      (SCKclock),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .spi_rx_i      (spi_rx),
    .spi_idle_i    (spi_idle),
    .spi_start_o   (spi_start),
    .spi_tx_o      (spi_tx),
    .spi_ctl_o     (spi_ctl),
    .wii1_report_o (wii1_report),
    .wii2_report_o (wii2_report),
    .power_down_o  (power_down_o)
  );

  spi_engine #(
    .SPI_LEN (SPI_LEN)
  ) i_spi_engine (
    .clk50    (clk50),
    .SCKclock (SCKclock),
    .start_i  (spi_start),
    .tx_i     (spi_tx),
    .rx_o     (spi_rx),
    .idle_o   (spi_idle),
    .sck_o    (eng_sck),
    .mosi_o   (eng_mosi),
    .miso_i   (spi_miso_i)
  );

  wii_report #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_wii_report (
    .clk50         (clk50),
    .SCKclock      (SCKclock),
    .wii1_report_i (wii1_report),
    .wii2_report_i (wii2_report),
    .host_load_i   (host_load_i),
    .host_sck_i    (host_sck_i),
    .host_miso_o   (host_miso_o)
  );

  // engine drives the pins, control bits can force them high
  assign spi_sck_o  = spi_ctl[SPI_SCK_BIT] | eng_sck;
  assign spi_mosi_o = spi_ctl[SPI_MOSI_BIT] | eng_mosi;
  assign spi_cs_o   = spi_ctl[SPI_CS_BIT];

endmodule

//--- source/io_regs.sv
`timescale 1ns/100ps

module io_regs
  import dazzler_bus_pkg::*;
  import dazzler_ctrl_pkg::*;
(
  input  logic                 clk50,
  input  logic                 SCKclock,

  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [BUS_AW-1:0]    wb_adr_i,
  input  logic [BUS_DW-1:0]    wb_dat_i,
  output logic [BUS_DW-1:0]    wb_dat_o,
  output logic                 wb_ack_o,

  input  logic [BUS_DW-1:0]    spi_rx_i,
  input  logic                 spi_idle_i,
  output logic                 spi_start_o,
  output logic [BUS_DW-1:0]    spi_tx_o,
  output logic [SPI_CTL_W-1:0] spi_ctl_o,

  output logic [REPORT_W-1:0]  wii1_report_o,
  output logic [REPORT_W-1:0]  wii2_report_o,

  output logic                 power_down_o
);

  logic                 bus_req;
  logic                 bus_wr;
  logic [BUS_DW-1:0]    rd_word;

  logic [REPORT_W-1:0]  wii1_q;
  logic [REPORT_W-1:0]  wii2_q;
  logic [SPI_CTL_W-1:0] spi_ctl_q;
  logic [BUS_DW-1:0]    sysctl_q;
  logic [BUS_DW-1:0]    ticks_q;

  //////////////////////////////
  // wishbone classic handshake
  //////////////////////////////
  // ~ack keeps a held strobe from being taken twice
  assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign bus_wr  = bus_req & wb_we_i;

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= bus_req;
      if (bus_req) begin
        wb_dat_o <= rd_word;  // held while ack is up
      end
    end
  end

  //////////////////////////////
  // register writes
  //////////////////////////////
  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      wii1_q    <= '0;
      wii2_q    <= '0;
      spi_ctl_q <= '0;
      sysctl_q  <= '0;
    end else if (bus_wr) begin
      case (io_addr_e'(wb_adr_i))
        WII1_LO:  wii1_q[0 +: BUS_DW]        <= wb_dat_i;
        WII1_MID: wii1_q[BUS_DW +: BUS_DW]   <= wb_dat_i;
        WII1_HI:  wii1_q[2*BUS_DW +: BUS_DW] <= wb_dat_i;
        WII2_LO:  wii2_q[0 +: BUS_DW]        <= wb_dat_i;
        WII2_MID: wii2_q[BUS_DW +: BUS_DW]   <= wb_dat_i;
        WII2_HI:  wii2_q[2*BUS_DW +: BUS_DW] <= wb_dat_i;
        SPI_CTL:  spi_ctl_q <= wb_dat_i[SPI_CTL_W-1:0];
        SYSCTL:   sysctl_q  <= wb_dat_i;
        default: ;  // read-only or unmapped
      endcase
    end
  end

  // free running, wraps
  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      ticks_q <= '0;
    end else begin
      ticks_q <= ticks_q + 1'b1;
    end
  end

  //////////////////////////////
  // read-back mux
  //////////////////////////////
  always_comb begin
    rd_word = '0;
    case (io_addr_e'(wb_adr_i))
      WII1_LO:  rd_word = wii1_q[0 +: BUS_DW];
      WII1_MID: rd_word = wii1_q[BUS_DW +: BUS_DW];
      WII1_HI:  rd_word = wii1_q[2*BUS_DW +: BUS_DW];
      WII2_LO:  rd_word = wii2_q[0 +: BUS_DW];
      WII2_MID: rd_word = wii2_q[BUS_DW +: BUS_DW];
      WII2_HI:  rd_word = wii2_q[2*BUS_DW +: BUS_DW];
      SPI_CTL:  rd_word = BUS_DW'(spi_ctl_q);
      SYSCTL:   rd_word = sysctl_q;
      TICKS:    rd_word = ticks_q;
      SPI_DATA: rd_word = spi_rx_i;
      SPI_STAT: rd_word[SPI_IDLE_BIT] = spi_idle_i;
      default:  rd_word = '0;
    endcase
  end

  // start pulse on the acking edge, engine loads wb data directly
  assign spi_start_o = bus_wr & (wb_adr_i == SPI_DATA);
  assign spi_tx_o    = wb_dat_i;
  assign spi_ctl_o   = spi_ctl_q;

  assign wii1_report_o = wii1_q;
  assign wii2_report_o = wii2_q;

  assign power_down_o = sysctl_q[SYSCTL_PD_BIT];

endmodule

//--- spi/spi_engine.sv
`timescale 1ns/100ps

module spi_engine #(
  parameter int SPI_LEN = 16
) (
  input  logic               clk50,
  input  logic               SCKclock,
  input  logic               start_i,
  input  logic [SPI_LEN-1:0] tx_i,
  output logic [SPI_LEN-1:0] rx_o,
  output logic               idle_o,
  output logic               sck_o,
  output logic               mosi_o,
  input  logic               miso_i
);

  // two half periods per bit
  localparam int CNT_W = $clog2(2 * SPI_LEN);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(2 * SPI_LEN - 1);

  logic               running;
  logic [CNT_W-1:0]   counter;
  logic [SPI_LEN-1:0] shifter;

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      running <= 1'b0;
      counter <= '0;
      shifter <= '0;
    end else if (start_i) begin
      // a start while busy simply restarts
      running <= 1'b1;
      counter <= '0;
      shifter <= tx_i;
    end else if (running) begin
      if (counter == CNT_LAST) begin
        running <= 1'b0;
        counter <= '0;
      end else begin
        counter <= counter + 1'b1;
      end
      if (counter[0]) begin
        shifter <= {shifter[SPI_LEN-2:0], miso_i};  // sck falling, msb first
      end
    end
  end

  assign sck_o  = counter[0];
  assign mosi_o = shifter[SPI_LEN-1];
  assign rx_o   = shifter;
  assign idle_o = ~running;

endmodule

//--- testbench/dazzler_trace.txt
# op addr val1 val2, hex; W writes val1, R expects val1, S sends val1 with slave word val2
# T reads TICKS val1 bus cycles apart, H reads the host word built from the stored reports
# reset values
R 004 0000 0000
R 005 0000 0000
R 006 0000 0000
R 007 0000 0000
R 008 0000 0000
R 009 0000 0000
R 010 0000 0000
R 014 0000 0000
R 020 0000 0000
R 021 0001 0000
R 000 0000 0000
# report words
W 004 c5e7 0000
W 005 39b2 0000
W 006 1234 0000
W 007 7f01 0000
W 008 a6c8 0000
W 009 fedc 0000
R 004 c5e7 0000
R 005 39b2 0000
R 006 1234 0000
R 007 7f01 0000
R 008 a6c8 0000
R 009 fedc 0000
# system control, spi control, unmapped
W 014 0001 0000
R 014 0001 0000
W 014 0a50 0000
R 014 0a50 0000
W 010 00ec 0000
R 010 002c 0000
W 003 ffff 0000
R 003 0000 0000
W 0ff 5a5a 0000
R 0ff 0000 0000
# spi transfers with cs high
S 020 a53c 3c96
S 020 0001 8000
S 020 ffff 0000
W 010 0000 0000
R 010 0000 0000
T 015 0005 0000
H 000 0000 0000
W 004 0f3a 0000
W 009 0123 0000
H 000 0000 0000

//--- testbench/tb_dazzler_io.sv
`timescale 1ns/100ps

module tb_dazzler_io
  import dazzler_bus_pkg::*;
();

  localparam int MAX_CYCLES = 40000;  // about ten times the trace run
  localparam int ACK_LIMIT  = 8;
  localparam int SPI_LIMIT  = 40;

  logic        clk50;
  logic        SCKclock;
  logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [11:0] wb_adr_i;
  logic [15:0] wb_dat_i, wb_dat_o;
  logic        spi_miso_i, spi_sck_o, spi_mosi_o, spi_cs_o;
  logic        host_load_i, host_sck_i, host_miso_o;
  logic        power_down_o;

  integer errors, ops, cyc_count, seed, fd, rc, gap, last_start, last_end, sck_rises;
  logic [7:0]     op;
  logic [11:0]    adr;
  logic [15:0]    v1, v2, rd;
  logic [8*128-1:0] junk;
  logic [47:0]    wii1_m, wii2_m;  // report model from bus writes
  logic [5:0]     ctl_m;
  logic [15:0]    slave_sr, mosi_cap;
  logic           done;

  dazzler_io_top i_dazzler_io_top (
    .clk50 (clk50), .SCKclock (SCKclock),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
    .spi_miso_i (spi_miso_i), .spi_sck_o (spi_sck_o), .spi_mosi_o (spi_mosi_o),
    .spi_cs_o (spi_cs_o), .host_load_i (host_load_i), .host_sck_i (host_sck_i),
    .host_miso_o (host_miso_o), .power_down_o (power_down_o)
  );

  always #50 clk50 = ~clk50;

  always @(posedge clk50) begin
    cyc_count <= cyc_count + 1;
    if (cyc_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("ops %0d errors %0d", ops, errors + 1);
      $display("TEST FAIL");
      $finish;
    end
  end

  // spi slave shifts out msb first and captures mosi on sck rising
  always @(posedge spi_sck_o) begin
    #10;
    mosi_cap   = {mosi_cap[14:0], spi_mosi_o};
    spi_miso_i = slave_sr[15];
    slave_sr   = {slave_sr[14:0], 1'b0};
    sck_rises  = sck_rises + 1;
  end

  task automatic report_mismatch(input string name, input logic [47:0] exp,
                                 input logic [47:0] got);
    $display("CHECK FAILED %s exp 0x%0h got 0x%0h at %0t", name, exp, got, $time);
    errors = errors + 1;
  endtask

  task automatic step_cycles(input integer n);
    repeat (n) @(posedge clk50);
    #10;
  endtask

  //////////////////////////////
  // bus master
  //////////////////////////////
  task automatic bus_access(input logic we, input logic [11:0] a, input logic [15:0] wd,
                            output logic [15:0] rdat);
    integer waited;
    logic   acked;
    step_cycles(1);
    last_start = cyc_count;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = a;
    wb_dat_i = wd;
    waited = 1;  // stb high for the first cycle already
    @(negedge clk50);
    acked = wb_ack_o;
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge clk50);
      waited = waited + 1;
      acked  = wb_ack_o;
    end
    if (!acked) begin
      $display("no ack within %0d cycles for address 0x%03h", ACK_LIMIT, a);
      errors = errors + 1;
    end else if (waited != 2) begin
      report_mismatch("ack latency", 2, waited);
    end
    rdat     = wb_dat_o;
    last_end = cyc_count;
    step_cycles(1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk50);
    if (wb_ack_o !== 1'b0) report_mismatch("wb_ack_o", 0, wb_ack_o);  // single cycle ack
  endtask

  // decoded bytes are zero padded at the top
  function automatic logic [47:0] decode_fields(input logic [47:0] raw);
    logic [7:0] b0, b1, b2, b3;
    logic [7:0] lx, ly, rx, ry, lt, rt;
    b0 = raw[7:0];
    b1 = raw[15:8];
    b2 = raw[23:16];
    b3 = raw[31:24];
    lx = b0 & 8'h3f;
    ly = b1 & 8'h3f;
    rx = {3'b000, b0[7:6], b1[7:6], b2[7]};
    ry = b2 & 8'h1f;
    lt = {3'b000, b2[6:5], b3[7:5]};
    rt = b3 & 8'h1f;
    return {rt, lt, ry, rx, ly, lx};
  endfunction

  task automatic host_readout(input logic [191:0] exp);
    integer i, pos;
    step_cycles(1);
    host_load_i = 1'b1;
    step_cycles(5);
    host_load_i = 1'b0;
    step_cycles(5);
    for (i = 0; i < 192; i = i + 1) begin
      pos = (i / 8) * 8 + 7 - (i % 8);  // ascending bytes with msb first
      @(negedge clk50);
      if (host_miso_o !== exp[pos]) report_mismatch("host_miso_o", exp[pos], host_miso_o);
      step_cycles(1);
      host_sck_i = 1'b1;
      step_cycles(5);
      host_sck_i = 1'b0;
      step_cycles(4);
    end
  endtask

  task automatic spi_transfer(input logic [11:0] a, input logic [15:0] tx,
                              input logic [15:0] slave_word);
    integer wr_end;
    logic [15:0] st;
    slave_sr  = slave_word;
    mosi_cap  = '0;
    sck_rises = 0;
    bus_access(1'b1, a, tx, st);
    wr_end = last_end;
    bus_access(1'b0, SPI_STAT, 16'h0, st);
    if (st !== 16'h0000) report_mismatch("spi_stat", 0, st);
    while (st[SPI_IDLE_BIT] !== 1'b1 && cyc_count - wr_end <= SPI_LIMIT) begin
      bus_access(1'b0, SPI_STAT, 16'h0, st);
    end
    if (st[SPI_IDLE_BIT] !== 1'b1 || last_end - wr_end > SPI_LIMIT) begin
      $display("spi transfer not idle within %0d cycles", SPI_LIMIT);
      errors = errors + 1;
    end
    bus_access(1'b0, SPI_DATA, 16'h0, st);
    if (st !== slave_word) report_mismatch("spi_rx", slave_word, st);
    if (mosi_cap !== tx) report_mismatch("spi_mosi_o", tx, mosi_cap);
    if (sck_rises != 16) report_mismatch("spi_sck_o rises", 16, sck_rises);
    if (spi_cs_o !== ctl_m[SPI_CS_BIT]) begin
      report_mismatch("spi_cs_o", ctl_m[SPI_CS_BIT], spi_cs_o);
    end
  endtask

  task automatic ticks_delta(input integer between);
    integer start0, span;
    logic [15:0] t0, t1, diff, scratch;
    bus_access(1'b0, TICKS, 16'h0, t0);
    start0 = last_start;
    repeat (between) bus_access(1'b0, SPI_STAT, 16'h0, scratch);
    bus_access(1'b0, TICKS, 16'h0, t1);
    span = last_end - start0;
    diff = t1 - t0;
    if (diff == 0 || diff >= span) report_mismatch("TICKS delta", span, diff);
  endtask

  //////////////////////////////
  // trace ops
  //////////////////////////////
  task automatic run_op;
    case (op)
      "W": begin
        bus_access(1'b1, adr, v1, rd);
        case (adr)
          WII1_LO:  wii1_m[15:0]  = v1;
          WII1_MID: wii1_m[31:16] = v1;
          WII1_HI:  wii1_m[47:32] = v1;
          WII2_LO:  wii2_m[15:0]  = v1;
          WII2_MID: wii2_m[31:16] = v1;
          WII2_HI:  wii2_m[47:32] = v1;
          SPI_CTL:  ctl_m = v1[5:0];
          default: ;
        endcase
        if (adr == SYSCTL && power_down_o !== v1[0]) begin
          report_mismatch("power_down_o", v1[0], power_down_o);
        end
        if (adr == SPI_CTL && spi_cs_o !== v1[SPI_CS_BIT]) begin
          report_mismatch("spi_cs_o", v1[SPI_CS_BIT], spi_cs_o);
        end
      end
      "R": begin
        bus_access(1'b0, adr, 16'h0, rd);
        if (rd !== v1) report_mismatch("wb_dat_o", v1, rd);
      end
      "S": spi_transfer(adr, v1, v2);
      "T": ticks_delta(v1);
      "H": host_readout({decode_fields(wii2_m), wii2_m, decode_fields(wii1_m), wii1_m});
      default: begin
        $display("unknown opcode in trace: %c", op);
        errors = errors + 1;
      end
    endcase
    ops = ops + 1;
  endtask

  initial begin
    clk50 = 1'b0;
    SCKclock = 1'b1;
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    wb_adr_i = '0;
    wb_dat_i = '0;
    spi_miso_i = 1'b0;
    host_load_i = 1'b0;
    host_sck_i = 1'b0;
    errors = 0;
    ops = 0;
    cyc_count = 0;
    seed = 32'ha11;
    done = 1'b0;
    wii1_m = '0;
    wii2_m = '0;
    ctl_m = '0;
    slave_sr = '0;
    mosi_cap = '0;
    sck_rises = 0;
    repeat (16) @(posedge clk50);
    #10 SCKclock = 1'b0;
    @(negedge clk50);
    if (wb_ack_o !== 1'b0) report_mismatch("wb_ack_o", 0, wb_ack_o);
    if (power_down_o !== 1'b0) report_mismatch("power_down_o", 0, power_down_o);
    if ({spi_sck_o, spi_mosi_o, spi_cs_o} !== 3'b000)
      report_mismatch("spi pins", 0, {spi_sck_o, spi_mosi_o, spi_cs_o});

    fd = $fopen("testbench/dazzler_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      errors = errors + 1;
      done = 1'b1;
    end
    while (!done) begin
      rc = $fscanf(fd, " %c", op);
      if (rc != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        rc = $fgets(junk, fd);  // comment line
      end else begin
        rc = $fscanf(fd, "%h %h %h", adr, v1, v2);
        run_op();
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk50);
      end
    end
    if (fd != 0) $fclose(fd);

    $display("ops %0d errors %0d", ops, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- wii/wii_report.sv
`timescale 1ns/100ps

module wii_report
  import dazzler_ctrl_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk50,
  input  logic                SCKclock,
  input  logic [REPORT_W-1:0] wii1_report_i,
  input  logic [REPORT_W-1:0] wii2_report_i,
  input  logic                host_load_i,
  input  logic                host_sck_i,
  output logic                host_miso_o
);

  logic [SYNC_STAGES-1:0]  load_sync;
  logic [SYNC_STAGES-1:0]  sck_sync;
  logic                    sck_prev;
  logic                    load_s;
  logic                    sck_rise;

  logic [REPORT_W-1:0]     wii1_dec;
  logic [REPORT_W-1:0]     wii2_dec;
  logic [READOUT_W-1:0]    sup_sr;
  logic [READOUT_IX_W-1:0] sup_ix;

  //////////////////////////////
  // field decoder
  //////////////////////////////
  // rx and lt are split across the input bytes
  function automatic logic [REPORT_W-1:0] decode_report(input logic [REPORT_W-1:0] r);
    logic [STICK_L_W-1:0] lx;
    logic [STICK_L_W-1:0] ly;
    logic [STICK_R_W-1:0] rx;
    logic [STICK_R_W-1:0] ry;
    logic [STICK_R_W-1:0] lt;
    logic [STICK_R_W-1:0] rt;
    lx      = r[5:0];
    rx[4:3] = r[7:6];
    ly      = r[13:8];
    rx[2:1] = r[15:14];
    ry      = r[20:16];
    lt[4:3] = r[22:21];
    rx[0]   = r[23];
    rt      = r[28:24];
    lt[2:0] = r[31:29];
    return {FIELD_W'(rt), FIELD_W'(lt), FIELD_W'(ry),
            FIELD_W'(rx), FIELD_W'(ly), FIELD_W'(lx)};
  endfunction

  assign wii1_dec = decode_report(wii1_report_i);
  assign wii2_dec = decode_report(wii2_report_i);

  //////////////////////////////
  // host pin synchronizers
  //////////////////////////////
  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      load_sync <= '0;
      sck_sync  <= '0;
      sck_prev  <= 1'b0;
    end else begin
      load_sync <= {load_sync[SYNC_STAGES-2:0], host_load_i};
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], host_sck_i};
      sck_prev  <= sck_sync[SYNC_STAGES-1];
    end
  end

  assign load_s   = load_sync[SYNC_STAGES-1];
  assign sck_rise = sck_sync[SYNC_STAGES-1] & ~sck_prev;

  //////////////////////////////
  // readout shift register
  //////////////////////////////
  always_ff @(posedge clk50) begin
    if (load_s) begin
      sup_sr <= {wii2_dec, wii2_report_i, wii1_dec, wii1_report_i};
    end
  end

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      sup_ix <= '0;
    end else if (load_s) begin
      sup_ix <= '0;
    end else if (sck_rise) begin
      sup_ix <= sup_ix + 1'b1;
    end
  end

  // bytes ascending, msb first inside a byte
  assign host_miso_o = sup_sr[{sup_ix[READOUT_IX_W-1:3], ~sup_ix[2:0]}];

endmodule
